//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_i2c_master
FILELIST := i2c_master.f
OBJ_DIR  := obj_dir
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- i2c_master.f
+incdir+src
src/i2c_bus_pkg.sv
src/i2c_ctrl_pkg.sv
src/i2c_cmd_latch.sv
src/i2c_bit_sequencer.sv
src/i2c_line_driver.sv
src/i2c_master.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

//--- src/i2c_bit_sequencer.sv
`default_nettype none

`include "i2c_params.svh"

module i2c_bit_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     go,
    input  logic [`I2C_ADDR_W:0]     addr_byte,
    input  logic [`I2C_DATA_W-1:0]   data_byte,
    input  i2c_bus_pkg::rw_e         cmd_rw,
    input  logic                     sda_sync,    // Synchronized bus SDA
    output logic                     scl_drive,
    output logic                     sda_drive,
    output logic                     sda_release, // 1 = let the slave drive
    output logic                     busy,
    output logic                     done,
    output logic                     ack_error,
    output logic [`I2C_DATA_W-1:0]   rx_data
);

    import i2c_bus_pkg::*;
    import i2c_ctrl_pkg::*;

    //====================================================================
    // Timing constants
    //====================================================================
    localparam int CNT_W = `I2C_CNT_W;
    localparam int BIT_W = $clog2(`I2C_DATA_W);

    localparam logic [CNT_W-1:0] QUARTER_LAST = CNT_W'(`I2C_QUARTER_CYCLES - 1);
    localparam logic [CNT_W-1:0] HALF_LAST    = CNT_W'(`I2C_HALF_CYCLES - 1);
    localparam logic [CNT_W-1:0] SAMPLE_CNT   = CNT_W'(`I2C_SAMPLE_POINT);
    localparam logic [BIT_W-1:0] LAST_BIT     = BIT_W'(`I2C_DATA_W - 1);

    seq_state_e              state;
    scl_phase_e              phase;       // Quarter within current bit
    logic [CNT_W-1:0]        cnt;         // Cycles within quarter or half step
    logic [BIT_W-1:0]        bit_cnt;
    logic [`I2C_DATA_W-1:0]  tx_shift;    // MSB goes out first
    logic [`I2C_DATA_W-1:0]  rx_shift;
    logic                    ack_ok;      // Last sampled ACK slot

    logic in_bit_slot;
    logic step_end;
    logic bit_end;
    logic last_bit;
    logic shift_bit;
    logic sample_now;
    logic scl_high;
    logic is_write;

    assign is_write    = (cmd_rw == RW_WRITE);
    assign in_bit_slot = state inside {ST_ADDR_BIT, ST_ADDR_ACK, ST_DATA_BIT, ST_DATA_ACK};

    // Bit slots step in quarters, START and STOP in halves
    assign step_end   = in_bit_slot ? (cnt == QUARTER_LAST) : (cnt == HALF_LAST);
    assign bit_end    = in_bit_slot && step_end && (phase == PH_HIGH_2);
    assign last_bit   = (bit_cnt == LAST_BIT);
    assign shift_bit  = bit_end && (state inside {ST_ADDR_BIT, ST_DATA_BIT});
    assign sample_now = (phase == PH_HIGH_1) && (cnt == SAMPLE_CNT);   // Covers sync lag
    assign scl_high   = (phase inside {PH_HIGH_1, PH_HIGH_2});

    assign busy    = (state != ST_IDLE);
    assign rx_data = rx_shift;

    //====================================================================
    // Quarter timer, SCL phase and bit counter
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            phase   <= PH_LOW_1;
            bit_cnt <= '0;
        end else if (state == ST_IDLE) begin
            cnt     <= '0;
            phase   <= PH_LOW_1;
            bit_cnt <= '0;
        end else if (step_end) begin
            cnt <= '0;
            if (in_bit_slot) begin
                phase <= scl_phase_e'(phase + 2'd1);   // Wraps to LOW_1 per bit
            end
            if (shift_bit) begin
                bit_cnt <= bit_cnt + 1'b1;            // Wraps to 0 after the byte
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    //====================================================================
    // State machine and status
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            done      <= 1'b0;
            ack_error <= 1'b0;
            ack_ok    <= 1'b0;
        end else begin
            done <= 1'b0;   // Pulse

            // ACK slots sample mid-high
            if (sample_now && (state inside {ST_ADDR_ACK, ST_DATA_ACK})) begin
                ack_ok <= (sda_sync == ACK_LEVEL);
            end

            case (state)
                ST_IDLE: begin
                    if (go) begin
                        ack_error <= 1'b0;
                        state     <= ST_START1;
                    end
                end
                ST_START1: if (step_end) state <= ST_START2;
                ST_START2: if (step_end) state <= ST_START3;
                ST_START3: if (step_end) state <= ST_ADDR_BIT;
                ST_ADDR_BIT: begin
                    if (bit_end && last_bit) begin
                        state <= ST_ADDR_ACK;
                    end
                end
                ST_ADDR_ACK: begin
                    if (bit_end) begin
                        if (ack_ok) begin
                            state <= ST_DATA_BIT;
                        end else begin
                            ack_error <= 1'b1;      // No slave, skip data
                            state     <= ST_STOP1;
                        end
                    end
                end
                ST_DATA_BIT: begin
                    if (bit_end && last_bit) begin
                        state <= ST_DATA_ACK;
                    end
                end
                ST_DATA_ACK: begin
                    if (bit_end) begin
                        if (is_write && !ack_ok) begin
                            ack_error <= 1'b1;      // Byte still completes
                        end
                        state <= ST_STOP1;
                    end
                end
                ST_STOP1: if (step_end) state <= ST_STOP2;
                ST_STOP2: if (step_end) state <= ST_STOP3;
                ST_STOP3: begin
                    if (step_end) begin
                        done  <= 1'b1;              // Same cycle busy drops
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //====================================================================
    // Shift registers
    //====================================================================
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && go) begin
            tx_shift <= addr_byte;
        end else if ((state == ST_ADDR_ACK) && bit_end) begin
            tx_shift <= data_byte;
        end else if (shift_bit) begin
            tx_shift <= {tx_shift[`I2C_DATA_W-2:0], 1'b0};
        end

        // Read bits arrive MSB first
        if ((state == ST_DATA_BIT) && !is_write && sample_now) begin
            rx_shift <= {rx_shift[`I2C_DATA_W-2:0], sda_sync};
        end
    end

    //====================================================================
    // Line levels per state
    //====================================================================
    always_comb begin
        scl_drive   = 1'b1;     // Idle and START1/STOP3 levels
        sda_drive   = 1'b1;
        sda_release = 1'b0;
        case (state)
            ST_START2, ST_STOP2: sda_drive = 1'b0;
            ST_START3, ST_STOP1: begin
                scl_drive = 1'b0;
                sda_drive = 1'b0;
            end
            ST_ADDR_BIT: begin
                scl_drive = scl_high;
                sda_drive = tx_shift[`I2C_DATA_W-1];
            end
            ST_ADDR_ACK: begin
                scl_drive   = scl_high;
                sda_release = 1'b1;
            end
            ST_DATA_BIT: begin
                scl_drive = scl_high;
                if (is_write) begin
                    sda_drive = tx_shift[`I2C_DATA_W-1];
                end else begin
                    sda_release = 1'b1;
                end
            end
            ST_DATA_ACK: begin
                scl_drive = scl_high;
                if (is_write) begin
                    sda_release = 1'b1;
                end else begin
                    sda_drive = ~ACK_LEVEL;         // NACK ends the read
                end
            end
            default: ;
        endcase
    end

    //====================================================================
    // Checks
    //====================================================================
    a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

    a_cnt_range : assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= CNT_W'(`I2C_HALF_CYCLES));

    // Timer, phase and bit count back at rest whenever the master is idle
    a_idle_rest : assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (cnt == '0) && (phase == PH_LOW_1) && (bit_cnt == '0));

endmodule : i2c_bit_sequencer

`default_nettype wire

//--- src/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    //====================================================================
    // Bus protocol encodings
    //====================================================================

    // R/W bit after the address
    typedef enum logic {
        RW_WRITE = 1'b0,
        RW_READ  = 1'b1
    } rw_e;

    // Quarter within one SCL bit
    typedef enum logic [1:0] {
        PH_LOW_1  = 2'd0,   // SDA may change here
        PH_LOW_2  = 2'd1,
        PH_HIGH_1 = 2'd2,   // Receiver samples here
        PH_HIGH_2 = 2'd3
    } scl_phase_e;

    // Receiver pulls SDA low to acknowledge
    localparam logic ACK_LEVEL = 1'b0;

endpackage : i2c_bus_pkg

`default_nettype wire

//--- src/i2c_cmd_latch.sv
`default_nettype none

`include "i2c_params.svh"

module i2c_cmd_latch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,       // Command strobe
    input  i2c_bus_pkg::rw_e         rw_bit,
    input  logic [`I2C_ADDR_W-1:0]   slave_addr,
    input  logic [`I2C_DATA_W-1:0]   tx_data,
    input  logic                     busy,        // From sequencer
    output logic                     go,
    output logic [`I2C_ADDR_W:0]     addr_byte,   // {address, rw}
    output logic [`I2C_DATA_W-1:0]   data_byte,
    output i2c_bus_pkg::rw_e         cmd_rw
);

    import i2c_bus_pkg::*;

    logic accept;

    // A go already in flight counts as busy, since busy only rises a cycle later
    assign accept = start && !busy && !go;

    // go pulses one cycle after the accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go     <= 1'b0;
            cmd_rw <= RW_WRITE;
        end else begin
            go <= accept;
            if (accept) begin
                cmd_rw <= rw_bit;   // Steers the data phase
            end
        end
    end

    // Payload held until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_byte <= {slave_addr, rw_bit};
            data_byte <= tx_data;
        end
    end

    //====================================================================
    // Checks
    //====================================================================

    // Sequencer must have returned to idle before a new command goes out
    a_go_not_busy : assert property (@(posedge clk) disable iff (!rst_n)
        !(go && busy));

endmodule : i2c_cmd_latch

`default_nettype wire

//--- src/i2c_ctrl_pkg.sv
`default_nettype none

package i2c_ctrl_pkg;

    //====================================================================
    // Sequencer state encoding
    //====================================================================
    typedef enum logic [3:0] {
        ST_IDLE     = 4'd0,     // Bus idle, both lines high

        // START condition
        ST_START1   = 4'd1,     // SCL high, SDA high
        ST_START2   = 4'd2,     // SDA falls with SCL high
        ST_START3   = 4'd3,     // SCL low, SDA low

        // Address byte and slave ACK
        ST_ADDR_BIT = 4'd4,
        ST_ADDR_ACK = 4'd5,

        // Data byte and ACK slot
        ST_DATA_BIT = 4'd6,     // Write drives, read samples
        ST_DATA_ACK = 4'd7,     // Slave ACK or master NACK

        // STOP condition
        ST_STOP1    = 4'd8,     // SCL low, SDA low
        ST_STOP2    = 4'd9,     // SCL high, SDA low
        ST_STOP3    = 4'd10     // SDA rises with SCL high
    } seq_state_e;

endpackage : i2c_ctrl_pkg

`default_nettype wire

//--- src/i2c_line_driver.sv
`default_nettype none

`include "i2c_params.svh"

module i2c_line_driver (
    input  logic clk,
    input  logic rst_n,
    input  logic scl_drive,
    input  logic sda_drive,
    input  logic sda_release,
    output logic scl,
    inout  wire  sda,           // Pull-up lives outside
    output logic sda_sync
);

    localparam int STAGES = `I2C_SYNC_STAGES;

    logic              scl_q;
    logic              sda_q;
    logic              sda_oe_q;    // 1 = master drives SDA
    logic [STAGES-1:0] sync_q;

    //====================================================================
    // Output registers
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q    <= 1'b1;       // Idle bus
            sda_q    <= 1'b1;
            sda_oe_q <= 1'b1;
        end else begin
            scl_q    <= scl_drive;
            sda_q    <= sda_drive;
            sda_oe_q <= ~sda_release;
        end
    end

    assign scl = scl_q;
    assign sda = sda_oe_q ? sda_q : 1'bz;

    //====================================================================
    // SDA input synchronizer
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '1;           // Bus idles high
        end else begin
            sync_q <= {sync_q[STAGES-2:0], sda};
        end
    end

    assign sda_sync = sync_q[STAGES-1];

    // Driven SDA must carry a known level onto the bus
    a_sda_known : assert property (@(posedge clk) disable iff (!rst_n)
        sda_oe_q |-> !$isunknown(sda_q));

endmodule : i2c_line_driver

`default_nettype wire

//--- src/i2c_master.sv
`default_nettype none

`include "i2c_params.svh"

module i2c_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  i2c_bus_pkg::rw_e         rw_bit,
    input  logic [`I2C_ADDR_W-1:0]   slave_addr,
    input  logic [`I2C_DATA_W-1:0]   tx_data,
    output logic [`I2C_DATA_W-1:0]   rx_data,
    output logic                     busy,
    output logic                     done,
    output logic                     ack_error,
    output logic                     scl,
    inout  wire                      sda
);

    import i2c_bus_pkg::*;

    // Latched command
    logic                    go;
    logic [`I2C_ADDR_W:0]    addr_byte;
    logic [`I2C_DATA_W-1:0]  data_byte;
    rw_e                     cmd_rw;

    // Line levels and sampled SDA
    logic scl_drive;
    logic sda_drive;
    logic sda_release;
    logic sda_sync;

    i2c_cmd_latch u_cmd_latch (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rw_bit     (rw_bit),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .busy       (busy),
        .go         (go),
        .addr_byte  (addr_byte),
        .data_byte  (data_byte),
        .cmd_rw     (cmd_rw)
    );

    i2c_bit_sequencer u_bit_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (go),
        .addr_byte   (addr_byte),
        .data_byte   (data_byte),
        .cmd_rw      (cmd_rw),
        .sda_sync    (sda_sync),
        .scl_drive   (scl_drive),
        .sda_drive   (sda_drive),
        .sda_release (sda_release),
        .busy        (busy),
        .done        (done),
        .ack_error   (ack_error),
        .rx_data     (rx_data)
    );

    i2c_line_driver u_line_driver (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl_drive   (scl_drive),
        .sda_drive   (sda_drive),
        .sda_release (sda_release),
        .scl         (scl),
        .sda         (sda),
        .sda_sync    (sda_sync)
    );

endmodule : i2c_master

`default_nettype wire

//--- src/i2c_params.svh
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// System and bus clock rates in Hz
`define I2C_CLK_FREQ        100_000_000
`define I2C_SCL_FREQ        100_000

// One SCL bit is four quarters
`define I2C_QUARTER_CYCLES  (`I2C_CLK_FREQ / (`I2C_SCL_FREQ * 4))
`define I2C_HALF_CYCLES     (2 * `I2C_QUARTER_CYCLES)   // Each START/STOP step
`define I2C_SAMPLE_POINT    (`I2C_QUARTER_CYCLES / 2)   // Middle of first high quarter

// Field and counter widths
`define I2C_CNT_W           10      // Holds up to a half period
`define I2C_ADDR_W          7
`define I2C_DATA_W          8

// SDA input synchronizer depth
`define I2C_SYNC_STAGES     2

`endif

//--- tb/i2c_slave_model.sv
`default_nettype none

`include "i2c_params.svh"

module i2c_slave_model #(
    parameter logic [`I2C_ADDR_W-1:0] DEV_ADDR = 7'h55
) (
    input  wire                     scl,
    inout  wire                     sda,
    input  logic [`I2C_DATA_W-1:0]  read_byte,       // Returned on a read
    input  logic                    nack_data,       // Refuse written data
    output logic [`I2C_DATA_W-1:0]  got_byte,
    output logic [7:0]              got_write,       // Captured byte count
    output logic                    saw_master_nack
);

    logic                    pull_low;   // Open-drain, only ever pulls down
    logic [`I2C_DATA_W-1:0]  shift;
    logic                    addr_hit;

    assign sda = pull_low ? 1'b0 : 1'bz;

    // Only called with the bus idle, so a falling SDA here is START
    task automatic wait_for_start();
        do begin
            @(negedge sda);
        end while (scl !== 1'b1);
    endtask

    // SDA may glitch high as SCL falls, hence the SCL check
    task automatic wait_for_stop();
        do begin
            @(posedge sda);
        end while (scl !== 1'b1);
    endtask

    // Returns on the SCL fall that opens the ACK slot
    task automatic receive_byte(output logic [`I2C_DATA_W-1:0] value);
        value = '0;
        for (int i = 0; i < `I2C_DATA_W; i++) begin
            @(posedge scl);
            value = {value[`I2C_DATA_W-2:0], sda};   // MSB first
        end
        @(negedge scl);
    endtask

    task automatic ack_slot(input logic ack);
        pull_low = ack;
        @(negedge scl);     // End of slot
        pull_low = 1'b0;
    endtask

    // Each bit is set up on the SCL fall before it
    task automatic send_byte(input logic [`I2C_DATA_W-1:0] value);
        for (int i = `I2C_DATA_W - 1; i >= 0; i--) begin
            pull_low = !value[i];
            @(negedge scl);
        end
        pull_low = 1'b0;    // Master owns the ACK slot
    endtask

    // ====================================================================
    // Transaction walker
    // ====================================================================
    initial begin
        pull_low        = 1'b0;
        shift           = '0;
        addr_hit        = 1'b0;
        got_byte        = '0;
        got_write       = '0;
        saw_master_nack = 1'b0;
        forever begin
            wait_for_start();
            saw_master_nack = 1'b0;
            receive_byte(shift);
            addr_hit = (shift[`I2C_DATA_W-1:1] == DEV_ADDR);
            ack_slot(addr_hit);
            if (addr_hit && shift[0]) begin
                send_byte(read_byte);
                @(posedge scl);
                saw_master_nack = (sda == 1'b1);   // High means no more bytes
                @(negedge scl);
            end else if (addr_hit) begin
                receive_byte(shift);
                got_byte  = shift;                 // Kept even when refused
                got_write = got_write + 8'd1;
                ack_slot(!nack_data);
            end
            wait_for_stop();
        end
    end

endmodule : i2c_slave_model

`default_nettype wire

//--- tb/tb_i2c_master.sv
`default_nettype none

`include "i2c_params.svh"

module tb_i2c_master;

    import i2c_bus_pkg::*;

    localparam logic [`I2C_ADDR_W-1:0] SLAVE_ADDR = 7'h55;
    localparam int NUM_ROWS     = 6;
    localparam int WAIT_CYCLES  = 30000;   // A full transfer takes 21000

    typedef struct packed {
        logic                    rw;
        logic [`I2C_ADDR_W-1:0]  addr;
        logic [`I2C_DATA_W-1:0]  tx_data;
        logic [`I2C_DATA_W-1:0]  read_byte;
        logic                    nack_data;
        logic [`I2C_DATA_W-1:0]  exp_rx;
        logic                    exp_ack_error;
        logic [7:0]              exp_count;      // Slave total after the row
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    rw_e                     rw_bit;
    logic [`I2C_ADDR_W-1:0]  slave_addr;
    logic [`I2C_DATA_W-1:0]  tx_data;
    logic [`I2C_DATA_W-1:0]  rx_data;
    logic                    busy;
    logic                    done;
    logic                    ack_error;
    wire                     scl;
    wire                     sda;

    // Slave side
    logic [`I2C_DATA_W-1:0]  read_byte;
    logic                    nack_data;
    logic [`I2C_DATA_W-1:0]  got_byte;
    logic [7:0]              got_write;
    logic                    saw_master_nack;

    row_t rows [NUM_ROWS];
    int   errors;
    int   timeouts;

    pullup (sda);

    i2c_master i2c_master_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rw_bit     (rw_bit),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) slave_i (
        .scl             (scl),
        .sda             (sda),
        .read_byte       (read_byte),
        .nack_data       (nack_data),
        .got_byte        (got_byte),
        .got_write       (got_write),
        .saw_master_nack (saw_master_nack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    // Data bytes random, expected values by hand
    task automatic fill_row(input int idx, input logic rw, input logic [`I2C_ADDR_W-1:0] addr,
                            input logic nack, input logic exp_err, input logic [7:0] exp_count);
        rows[idx].rw            = rw;
        rows[idx].addr          = addr;
        rows[idx].tx_data       = 8'($urandom());
        rows[idx].read_byte     = 8'($urandom());
        rows[idx].nack_data     = nack;
        rows[idx].exp_rx        = rows[idx].read_byte;   // Slave returns it as is
        rows[idx].exp_ack_error = exp_err;
        rows[idx].exp_count     = exp_count;
    endtask

    task automatic pulse_start(input rw_e rw, input logic [`I2C_ADDR_W-1:0] addr,
                               input logic [`I2C_DATA_W-1:0] data);
        @(negedge clk);
        start      <= 1'b1;
        rw_bit     <= rw;
        slave_addr <= addr;
        tx_data    <= data;
        @(negedge clk);
        start      <= 1'b0;
    endtask

    task automatic wait_for_done(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < WAIT_CYCLES && !seen; i++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout at %0t: done never pulsed within %0d cycles", $time, WAIT_CYCLES);
        end
    endtask

    task automatic wait_for_busy(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < 100 && !seen; i++) begin
            @(negedge clk);
            seen = busy;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout at %0t: master never went busy after start", $time);
        end
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        logic seen;
        logic is_read;
        logic hit;
        row     = rows[idx];
        is_read = (row.rw == RW_READ);
        hit     = (row.addr == SLAVE_ADDR);
        @(negedge clk);
        read_byte <= row.read_byte;
        nack_data <= row.nack_data;
        pulse_start(rw_e'(row.rw), row.addr, row.tx_data);
        wait_for_done(seen);
        if (seen) begin
            check_value("busy", 32'(busy), 32'd0);     // Already low with done
            check_value("ack_error", 32'(ack_error), 32'(row.exp_ack_error));
            check_value("got_write", 32'(got_write), 32'(row.exp_count));
            check_value("saw_master_nack", 32'(saw_master_nack), 32'(is_read && hit));
            if (is_read) begin
                check_value("rx_data", 32'(rx_data), 32'(row.exp_rx));
            end else if (hit) begin
                check_value("got_byte", 32'(got_byte), 32'(row.tx_data));
            end
        end
    endtask

    // Second command lands in the START condition and must be dropped
    task automatic start_while_busy();
        logic [`I2C_DATA_W-1:0] first_data;
        logic [7:0]             count_before;
        logic                   seen;
        first_data   = 8'($urandom());
        count_before = got_write;
        pulse_start(RW_WRITE, SLAVE_ADDR, first_data);
        wait_for_busy(seen);
        if (seen) begin
            repeat (1000) @(negedge clk);
            pulse_start(RW_WRITE, SLAVE_ADDR, ~first_data);
            wait_for_done(seen);
            if (seen) begin
                check_value("got_write", 32'(got_write), 32'(count_before + 8'd1));
                check_value("got_byte", 32'(got_byte), 32'(first_data));
                check_value("ack_error", 32'(ack_error), 32'd0);
                repeat (10) @(negedge clk);
                check_value("busy", 32'(busy), 32'd0);
            end
        end
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================
    initial begin
        errors     = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        rw_bit     = RW_WRITE;
        slave_addr = '0;
        tx_data    = '0;
        read_byte  = '0;
        nack_data  = 1'b0;
        void'($urandom(32'h859c_8bbd));

        //       rw    addr        nack  err   count
        fill_row(0, 1'b0, SLAVE_ADDR, 1'b0, 1'b0, 8'd1);
        fill_row(1, 1'b1, SLAVE_ADDR, 1'b0, 1'b0, 8'd1);
        fill_row(2, 1'b0, 7'h2A,      1'b0, 1'b1, 8'd1);   // Nobody answers
        fill_row(3, 1'b0, SLAVE_ADDR, 1'b1, 1'b1, 8'd2);   // Refused but captured
        fill_row(4, 1'b1, SLAVE_ADDR, 1'b0, 1'b0, 8'd2);
        fill_row(5, 1'b0, SLAVE_ADDR, 1'b0, 1'b0, 8'd3);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("scl", 32'(scl), 32'd1);               // Idle bus
        check_value("sda", 32'(sda), 32'd1);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("ack_error", 32'(ack_error), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        start_while_busy();

        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_i2c_master

`default_nettype wire
